//--- vid_pkg.sv
package vid_pkg;

	////////////////////
	// Basic widths
	////////////////////
	typedef logic [10:0] pix_cnt_t; // H or V count
	typedef logic [11:0] aux_col_t; // Start column of an aux burst
	typedef logic [3:0]  aux_nib_t; // One aux channel value

	// Aux word as it sits in the queue
	typedef struct packed {
		aux_col_t col;  // Column where ade rises
		aux_nib_t aux2; // Most significant nibble
		aux_nib_t aux1;
		aux_nib_t aux0;
	} aux_word_t;

	// Switch codes of the board
	typedef enum logic [3:0] {
		MODE_VGA    = 4'b0000,
		MODE_SVGA   = 4'b0001,
		MODE_720P   = 4'b0010,
		MODE_XGA    = 4'b0011,
		MODE_SXGA   = 4'b1000,
		MODE_CAMERA = 4'b1001
	} vid_mode_e;

	////////////////////
	// Timing records
	////////////////////
	typedef struct packed {
		pix_cnt_t h_active; // Live pixels
		pix_cnt_t h_fporch;
		pix_cnt_t h_sync;   // HSYNC pulse width
		pix_cnt_t h_bporch;
		pix_cnt_t v_active; // Live lines
		pix_cnt_t v_fporch;
		pix_cnt_t v_sync;   // VSYNC pulse width
		pix_cnt_t v_bporch;
		logic     neg_pol;  // 1 means negative sync
	} mode_timing_t;

	typedef struct packed {
		pix_cnt_t hcount;
		pix_cnt_t vcount;
		logic     hblnk;
		logic     vblnk;
		logic     hsync_raw; // Active high, before polarity
		logic     vsync_raw;
	} raster_t;

	typedef struct packed {
		logic     ade; // Aux data enable
		aux_nib_t aux2;
		aux_nib_t aux1;
		aux_nib_t aux0;
	} aux_out_t;

	// Pack one table row
	function automatic mode_timing_t mk_timing(
		input pix_cnt_t ha, input pix_cnt_t hf, input pix_cnt_t hs, input pix_cnt_t hb,
		input pix_cnt_t va, input pix_cnt_t vf, input pix_cnt_t vs, input pix_cnt_t vb,
		input logic     neg
	);
		return '{h_active: ha, h_fporch: hf, h_sync: hs, h_bporch: hb,
			v_active: va, v_fporch: vf, v_sync: vs, v_bporch: vb, neg_pol: neg};
	endfunction

	// Mode table, unknown codes give 720p
	function automatic mode_timing_t mode_timing_lut(input vid_mode_e mode);
		case (mode)
			MODE_VGA:    return mk_timing(11'd640,  11'd16,  11'd96,  11'd48,
				11'd480,  11'd10, 11'd2, 11'd33, 1'b1); // 800 x 525
			MODE_SVGA:   return mk_timing(11'd800,  11'd40,  11'd128, 11'd88,
				11'd600,  11'd1,  11'd4, 11'd23, 1'b0);
			MODE_XGA:    return mk_timing(11'd1024, 11'd24,  11'd136, 11'd160,
				11'd768,  11'd3,  11'd6, 11'd29, 1'b1);
			MODE_SXGA:   return mk_timing(11'd1280, 11'd48,  11'd112, 11'd248,
				11'd1024, 11'd1,  11'd3, 11'd38, 1'b0);
			MODE_CAMERA: return mk_timing(11'd1280, 11'd110, 11'd39,  11'd220,
				11'd720,  11'd4,  11'd4, 11'd22, 1'b0); // Short hsync
			MODE_720P:   return mk_timing(11'd1280, 11'd110, 11'd40,  11'd220,
				11'd720,  11'd5,  11'd5, 11'd20, 1'b0);
			default:     return mk_timing(11'd1280, 11'd110, 11'd40,  11'd220,
				11'd720,  11'd5,  11'd5, 11'd20, 1'b0); // Fallback 720p
		endcase
	endfunction

	// Cycles per line
	function automatic pix_cnt_t h_total(input mode_timing_t t);
		return t.h_active + t.h_fporch + t.h_sync + t.h_bporch;
	endfunction

	// Lines per frame
	function automatic pix_cnt_t v_total(input mode_timing_t t);
		return t.v_active + t.v_fporch + t.v_sync + t.v_bporch;
	endfunction

endpackage

//--- mode_select.sv
`timescale 1ns/1ps

module mode_select import vid_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 65536 // Hold time of a new code
) (
	input  logic         clk50m_bufg,
	input  logic         RSTBTN,
	input  logic [3:0]   sw,      // Raw board switches
	output mode_timing_t timing,  // Timing of the accepted mode
	output logic         restart  // One cycle on each mode change
);

	localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

	logic [3:0]    sw_meta;   // First sync flop
	logic [3:0]    sw_sync;   // Second sync flop
	logic [3:0]    sw_stable; // Last seen synchronized code
	logic [3:0]    mode_code; // Accepted code, raw so undefined codes stick
	logic [CW-1:0] deb_cnt;
	logic          settled;

	// Code held long enough
	assign settled = (deb_cnt == CW'(DEBOUNCE_CYCLES - 1));

	////////////////////
	// Sync and debounce
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta   <= 4'b0000;
			sw_sync   <= 4'b0000;
			sw_stable <= 4'b0000;
			deb_cnt   <= '0;
			mode_code <= MODE_VGA; // Start in VGA
			timing    <= mode_timing_lut(MODE_VGA);
			restart   <= 1'b0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			restart <= 1'b0; // Pulse only

			if (sw_sync != sw_stable) begin
				// Switches moved, start counting again
				sw_stable <= sw_sync;
				deb_cnt   <= '0;
			end else if (sw_stable != mode_code) begin
				if (settled) begin
					mode_code <= sw_stable;
					timing    <= mode_timing_lut(vid_mode_e'(sw_stable)); // LUT covers bad codes
					restart   <= 1'b1;
					deb_cnt   <= '0;
				end else begin
					deb_cnt <= deb_cnt + 1'b1;
				end
			end
			// Same code as the current mode leaves the counter idle
		end
	end

endmodule

//--- raster_timing.sv
`timescale 1ns/1ps

module raster_timing import vid_pkg::*; (
	input  logic         clk50m_bufg,
	input  logic         RSTBTN,
	input  logic         restart, // Back to the top left corner
	input  mode_timing_t timing,
	output raster_t      raster
);

	pix_cnt_t htot_m1;  // Last column
	pix_cnt_t vtot_m1;  // Last line
	pix_cnt_t h_nx;
	pix_cnt_t v_nx;
	logic     h_wrap;
	raster_t  raster_nx;

	// Window test for the sync pulses
	function automatic logic in_win(input pix_cnt_t cnt, input pix_cnt_t lo, input pix_cnt_t len);
		return (cnt >= lo) && (cnt < lo + len);
	endfunction

	assign htot_m1 = h_total(timing) - 11'd1;
	assign vtot_m1 = v_total(timing) - 11'd1;
	assign h_wrap  = (raster.hcount == htot_m1);

	////////////////////
	// Next counts
	////////////////////
	always_comb begin
		if (restart) begin
			h_nx = '0;
			v_nx = '0;
		end else begin
			h_nx = h_wrap ? '0 : raster.hcount + 11'd1;
			if (!h_wrap)
				v_nx = raster.vcount; // Line still running
			else if (raster.vcount == vtot_m1)
				v_nx = '0;            // End of frame
			else
				v_nx = raster.vcount + 11'd1;
		end
	end

	// Flags computed from the next counts so they line up with them
	always_comb begin
		raster_nx.hcount    = h_nx;
		raster_nx.vcount    = v_nx;
		raster_nx.hblnk     = (h_nx >= timing.h_active);
		raster_nx.vblnk     = (v_nx >= timing.v_active);
		raster_nx.hsync_raw = in_win(h_nx, timing.h_active + timing.h_fporch, timing.h_sync);
		raster_nx.vsync_raw = in_win(v_nx, timing.v_active + timing.v_fporch, timing.v_sync);
	end

	////////////////////
	// Counter registers
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN)
			raster <= '0; // Counts 0, no blank, no sync
		else
			raster <= raster_nx;
	end

endmodule

//--- aux_scheduler.sv
`timescale 1ns/1ps

module aux_scheduler import vid_pkg::*; #(
	parameter int AUX_BURST = 32 // ade cycles per word
) (
	input  logic         clk50m_bufg,
	input  logic         RSTBTN,
	input  logic         restart,
	input  mode_timing_t timing,
	input  raster_t      raster,
	input  logic         aux_valid, // Queue not empty
	input  aux_word_t    aux_word,  // Head of the FWFT queue
	output logic         aux_take,  // Pop strobe
	output aux_out_t     aux
);

	localparam int BW = $clog2(AUX_BURST + 1);

	typedef enum logic [1:0] {
		IDLE,     // Waiting for a word
		TAKE,     // Word popped, checking column
		WAIT_COL, // Waiting for the start column
		BURST     // ade high
	} aux_state_e;

	aux_state_e    state;
	aux_word_t     word_q;    // Popped word
	logic [BW-1:0] burst_cnt;
	logic          ade_q;
	aux_col_t      win_lo;    // First legal column
	aux_col_t      win_hi;    // Last legal column
	logic          col_ok;
	logic          col_hit;
	logic          pop;

	////////////////////
	// Column checks
	////////////////////
	assign win_lo  = {1'b0, timing.h_active};
	assign win_hi  = {1'b0, h_total(timing)} - aux_col_t'(AUX_BURST); // Burst ends by line end
	assign col_ok  = (word_q.col >= win_lo) && (word_q.col <= win_hi);
	assign col_hit = (({1'b0, raster.hcount} + 12'd1) == word_q.col); // One early, ade is registered
	assign pop     = (state == IDLE) && aux_valid && !restart;

	////////////////////
	// Scheduler FSM
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			state     <= IDLE;
			aux_take  <= 1'b0;
			ade_q     <= 1'b0;
			burst_cnt <= '0;
		end else begin
			aux_take <= 1'b0; // Single cycle strobe
			case (state)
				IDLE: begin
					if (aux_valid) begin
						aux_take <= 1'b1;
						state    <= TAKE;
					end
				end
				TAKE: begin
					// Out of window words are dropped here
					state <= col_ok ? WAIT_COL : IDLE;
				end
				WAIT_COL: begin
					if (col_hit) begin
						ade_q     <= 1'b1;
						burst_cnt <= '0;
						state     <= BURST;
					end
				end
				BURST: begin
					if (burst_cnt == BW'(AUX_BURST - 1)) begin
						ade_q <= 1'b0; // Last burst cycle
						state <= IDLE;
					end else begin
						burst_cnt <= burst_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Word capture at the pop
	always_ff @(posedge clk50m_bufg) begin
		if (pop)
			word_q <= aux_word;
	end

	// Nibbles held for the whole burst
	assign aux = '{ade: ade_q, aux2: word_q.aux2, aux1: word_q.aux1, aux0: word_q.aux0};

endmodule

//--- video_out_stage.sv
`timescale 1ns/1ps

module video_out_stage import vid_pkg::*; (
	input  logic         clk50m_bufg,
	input  logic         RSTBTN,
	input  mode_timing_t timing, // Only the polarity bit
	input  raster_t      raster,
	input  aux_out_t     aux,
	output logic         hsync,
	output logic         vsync,
	output logic         vde,
	output logic         ade,
	output aux_nib_t     aux0,
	output aux_nib_t     aux1,
	output aux_nib_t     aux2
);

	logic     hsync_s1;
	logic     vsync_s1;
	logic     vde_s1;
	logic     ade_s1;
	aux_nib_t aux0_s1;
	aux_nib_t aux1_s1;
	aux_nib_t aux2_s1;

	////////////////////
	// Control pipe
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_s1 <= timing.neg_pol; // Inactive level
			vsync_s1 <= timing.neg_pol;
			vde_s1   <= 1'b0;
			ade_s1   <= 1'b0;
			hsync    <= timing.neg_pol;
			vsync    <= timing.neg_pol;
			vde      <= 1'b0;
			ade      <= 1'b0;
		end else begin
			hsync_s1 <= raster.hsync_raw ^ timing.neg_pol; // Apply polarity
			vsync_s1 <= raster.vsync_raw ^ timing.neg_pol;
			vde_s1   <= !raster.hblnk && !raster.vblnk;    // Live area
			ade_s1   <= aux.ade;
			hsync    <= hsync_s1;
			vsync    <= vsync_s1;
			vde      <= vde_s1;
			ade      <= ade_s1;
		end
	end

	// Aux nibbles, same two stages
	always_ff @(posedge clk50m_bufg) begin
		aux0_s1 <= aux.aux0;
		aux1_s1 <= aux.aux1;
		aux2_s1 <= aux.aux2;
		aux0    <= aux0_s1;
		aux1    <= aux1_s1;
		aux2    <= aux2_s1;
	end

endmodule

//--- dvi_timing_top.sv
`timescale 1ns/1ps

module dvi_timing_top import vid_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 65536, // Switch hold time
	parameter int AUX_BURST       = 32     // ade burst length
) (
	input  logic       clk50m_bufg,
	input  logic       RSTBTN,
	input  logic [3:0] sw,
	input  logic       aux_valid,
	input  aux_word_t  aux_word,
	output logic       aux_take,
	output logic       hsync,
	output logic       vsync,
	output logic       vde,
	output logic       ade,
	output aux_nib_t   aux0,
	output aux_nib_t   aux1,
	output aux_nib_t   aux2
);

	mode_timing_t timing;  // Current mode table row
	logic         restart; // Mode change pulse
	raster_t      raster;
	aux_out_t     aux;

	////////////////////
	// Mode select
	////////////////////
	mode_select #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_mode_select (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.timing     (timing),
		.restart    (restart)
	);

	// Raster counters
	raster_timing u_raster_timing (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.restart    (restart),
		.timing     (timing),
		.raster     (raster)
	);

	// Aux bursts in hblank
	aux_scheduler #(
		.AUX_BURST(AUX_BURST)
	) u_aux_scheduler (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.restart    (restart),
		.timing     (timing),
		.raster     (raster),
		.aux_valid  (aux_valid),
		.aux_word   (aux_word),
		.aux_take   (aux_take),
		.aux        (aux)
	);

	////////////////////
	// Output registers
	////////////////////
	video_out_stage u_video_out_stage (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.timing     (timing),
		.raster     (raster),
		.aux        (aux),
		.hsync      (hsync),
		.vsync      (vsync),
		.vde        (vde),
		.ade        (ade),
		.aux0       (aux0),
		.aux1       (aux1),
		.aux2       (aux2)
	);

endmodule

//--- tb_dvi_checks.sv
`timescale 1ns/1ps

module tb_dvi_checks #(
	parameter int AUX_BURST = 32
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        hsync,
	input  logic        vde,
	input  logic        ade,
	input  logic        aux_take,
	input  logic        aux_valid,
	input  logic [3:0]  aux0,
	input  logic [3:0]  aux1,
	input  logic [3:0]  aux2,
	input  logic [11:0] h_active, // Model values of the mode
	input  logic [11:0] h_fporch,
	input  logic [11:0] h_total,
	input  logic        neg_pol,
	input  logic [11:0] exp_col,  // Expected start column
	input  logic [11:0] exp_nib,  // {aux2, aux1, aux0}
	output int          errors,
	output int          bursts    // Finished bursts
);

	logic hs_act;
	logic hs_prev;
	logic ade_prev;
	int   col;                     // Output side column, rebuilt from hsync
	int   run;                     // ade length so far

	initial begin
		errors   = 0;
		bursts   = 0;
		col      = 0;
		run      = 0;
		hs_prev  = 1'b0;
		ade_prev = 1'b0;
	end

	////////////////////
	// Output monitor
	////////////////////
	always @(negedge clk) begin
		if (!rst) begin
			hs_act = hsync ^ neg_pol;
			if (hs_act && !hs_prev)
				col = h_active + h_fporch; // Sync starts after front porch
			else if (col == h_total - 1)
				col = 0;
			else
				col = col + 1;

			assert (!(ade && vde)) else begin
				$display("[ERROR] %0t ade and vde high together", $time);
				errors++;
			end
			assert (!(aux_take && !aux_valid)) else begin
				$display("[ERROR] %0t aux_take with empty queue", $time);
				errors++;
			end

			if (ade) begin
				if (!ade_prev) begin
					run = 0;
					// Same as column minus active after vde falls
					assert (col == exp_col) else begin
						$display("[ERROR] %0t burst at column %0d, expected %0d", $time,
							col, exp_col);
						errors++;
					end
				end
				run++;
				assert ({aux2, aux1, aux0} == exp_nib) else begin
					$display("[ERROR] %0t nibbles %h, expected %h", $time,
						{aux2, aux1, aux0}, exp_nib);
					errors++;
				end
			end else if (ade_prev) begin
				assert (run == AUX_BURST) else begin
					$display("[ERROR] %0t burst length %0d", $time, run);
					errors++;
				end
				bursts++;
			end
			hs_prev  = hs_act;
			ade_prev = ade;
		end
	end

endmodule

//--- tb_dvi_timing.sv
`timescale 1ns/1ps

module tb_dvi_timing;

	localparam int DEB       = 64;   // Short debounce for simulation
	localparam int BURST     = 32;
	localparam int N_MODES   = 5;    // Random mode changes
	localparam int N_AUX     = 8;    // In range words
	localparam int N_BAD     = 4;    // Out of range words
	localparam int LINE_MAX  = 2200; // Above the longest line of any mode
	localparam int VGA_FRAME = 800 * 525;
	localparam longint WD_CYCLES = 3 * VGA_FRAME + (N_MODES + 3) * (DEB + 8 + 8 * LINE_MAX)
		+ (N_AUX + N_BAD + 2) * 4 * LINE_MAX;

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  sw;
	logic        aux_valid;
	logic [23:0] aux_word;      // {col, aux2, aux1, aux0}
	logic        aux_take;
	logic        hsync;
	logic        vsync;
	logic        vde;
	logic        ade;
	logic [3:0]  aux0;
	logic [3:0]  aux1;
	logic [3:0]  aux2;

	logic [11:0] m_active;      // Model of the current mode
	logic [11:0] m_fporch;
	logic [11:0] m_sync;
	logic [11:0] m_bporch;
	logic [11:0] m_total;
	logic        m_neg;
	logic [11:0] exp_col;       // Word under test
	logic [11:0] exp_nib;
	int          errors;        // Top level check failures
	int          chk_errors;
	int          bursts;

	dvi_timing_top #(
		.DEBOUNCE_CYCLES(DEB),
		.AUX_BURST      (BURST)
	) dut_i (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.aux_valid  (aux_valid),
		.aux_word   (aux_word),
		.aux_take   (aux_take),
		.hsync      (hsync),
		.vsync      (vsync),
		.vde        (vde),
		.ade        (ade),
		.aux0       (aux0),
		.aux1       (aux1),
		.aux2       (aux2)
	);

	tb_dvi_checks #(
		.AUX_BURST(BURST)
	) chk_i (
		.clk      (clk50m_bufg),
		.rst      (RSTBTN),
		.hsync    (hsync),
		.vde      (vde),
		.ade      (ade),
		.aux_take (aux_take),
		.aux_valid(aux_valid),
		.aux0     (aux0),
		.aux1     (aux1),
		.aux2     (aux2),
		.h_active (m_active),
		.h_fporch (m_fporch),
		.h_total  (m_total),
		.neg_pol  (m_neg),
		.exp_col  (exp_col),
		.exp_nib  (exp_nib),
		.errors   (chk_errors),
		.bursts   (bursts)
	);

	////////////////////
	// Clock, watchdog
	////////////////////
	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	initial begin
		#(WD_CYCLES * 20);
		$display("Timeout: the tests did not finish in the expected time");
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////
	// Reference model
	////////////////////
	task automatic set_model(input int a, input int f, input int s, input int b, input logic n);
		m_active = a;
		m_fporch = f;
		m_sync   = s;
		m_bporch = b;
		m_total  = a + f + s + b; // Line length
		m_neg    = n;
	endtask

	// Horizontal values per switch code
	task automatic ref_mode(input logic [3:0] code);
		case (code)
			4'b0000: set_model(640, 16, 96, 48, 1'b1);     // VGA
			4'b0001: set_model(800, 40, 128, 88, 1'b0);    // SVGA
			4'b0011: set_model(1024, 24, 136, 160, 1'b1);  // XGA
			4'b1000: set_model(1280, 48, 112, 248, 1'b0);  // SXGA
			4'b1001: set_model(1280, 110, 39, 220, 1'b0);  // Camera
			default: set_model(1280, 110, 40, 220, 1'b0);  // 720p and unknown
		endcase
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk50m_bufg);
		#2;
	endtask

	task automatic wait_hsync_start();
		@(negedge clk50m_bufg);
		while (hsync ^ m_neg) @(negedge clk50m_bufg);  // Leave current pulse
		while (!(hsync ^ m_neg)) @(negedge clk50m_bufg);
	endtask

	// One active run, then one sync period, all sampled at negedge
	task automatic measure_line(output int period, output int sync_w, output int act_w,
		output logic neg);
		logic idle;
		@(negedge clk50m_bufg);
		while (vde) @(negedge clk50m_bufg);
		while (!vde) @(negedge clk50m_bufg);
		act_w = 0;
		idle  = hsync;                               // Inactive level in live video
		while (vde) begin
			act_w++;
			@(negedge clk50m_bufg);
		end
		neg = idle;
		while (hsync == idle) @(negedge clk50m_bufg);
		sync_w = 0;
		while (hsync != idle) begin
			sync_w++;
			@(negedge clk50m_bufg);
		end
		period = sync_w;
		while (hsync == idle) begin
			period++;
			@(negedge clk50m_bufg);
		end
	endtask

	task automatic change_mode(input logic [3:0] code);
		int per;
		int sw_w;
		int act;
		logic neg;
		wait_cycles(1);
		sw = code;
		ref_mode(code);
		wait_cycles(DEB + 8);                        // Past sync and debounce
		measure_line(per, sw_w, act, neg);
		assert (per == m_total && sw_w == m_sync && act == m_active && neg == m_neg) else begin
			$display("[ERROR] %0t mode %b: period %0d sync %0d act %0d neg %0b", $time,
				code, per, sw_w, act, neg);
			errors++;
		end
	endtask

	// Test 1, a whole VGA frame
	task automatic check_vga_frame();
		int cyc;
		int lines;
		int act_lines;
		int hs_last;
		int hs_run;
		int vde_run;
		logic hs_p;
		logic vde_p;
		logic vs_p;
		@(negedge clk50m_bufg);
		while (!vsync) @(negedge clk50m_bufg);
		while (vsync) @(negedge clk50m_bufg);      // Frame start, sync low
		cyc = 0;
		lines = 0;
		act_lines = 0;
		hs_last = -1;
		hs_run = 0;
		vde_run = 0;
		hs_p = !hsync;
		vde_p = vde;
		vs_p = 1'b1;
		do begin
			@(negedge clk50m_bufg);
			cyc++;
			if (!hsync && !hs_p) begin
				if (hs_last >= 0)
					assert (cyc - hs_last == 800) else begin
						$display("[ERROR] %0t VGA line period %0d", $time, cyc - hs_last);
						errors++;
					end
				hs_last = cyc;
				lines++;
			end
			if (!hsync)
				hs_run++;
			else if (hs_p) begin
				assert (hs_run == 96) else begin
					$display("[ERROR] %0t VGA hsync width %0d", $time, hs_run);
					errors++;
				end
				hs_run = 0;
			end
			if (vde)
				vde_run++;
			else if (vde_p) begin
				assert (vde_run == 640) else begin
					$display("[ERROR] %0t VGA active width %0d", $time, vde_run);
					errors++;
				end
				act_lines++;
				vde_run = 0;
			end
			hs_p = !hsync;
			vde_p = vde;
			vs_p = !vsync ? vs_p : 1'b0;
		end while (!(!vsync && !vs_p));
		assert (cyc == VGA_FRAME && lines == 525 && act_lines == 480) else begin
			$display("[ERROR] %0t VGA frame %0d cycles %0d lines %0d active", $time,
				cyc, lines, act_lines);
			errors++;
		end
	endtask

	// Present one word until it is popped
	task automatic send_word(input logic [11:0] col, input logic [11:0] nib);
		wait_cycles(1);
		exp_col   = col;
		exp_nib   = nib;
		aux_word  = {col, nib};
		aux_valid = 1'b1;
		@(negedge clk50m_bufg);
		while (!aux_take) @(negedge clk50m_bufg);
		@(posedge clk50m_bufg);
		#2 aux_valid = 1'b0;
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		logic [3:0] code;
		logic [3:0] other;
		longint t0;
		longint t1;
		int nb;
		int col;
		void'($urandom(66));
		RSTBTN    = 1'b1;
		sw        = 4'b0000;
		aux_valid = 1'b0;
		aux_word  = '0;
		exp_col   = '0;
		exp_nib   = '0;
		errors    = 0;
		ref_mode(4'b0000);
		repeat (16) @(posedge clk50m_bufg);
		#2 RSTBTN = 1'b0;

		check_vga_frame();

		// Test 2, random codes, first one undefined
		for (int i = 0; i < N_MODES; i++) begin
			do
				code = $urandom % 16;
			while (i == 0 && (code inside {4'h0, 4'h1, 4'h2, 4'h3, 4'h8, 4'h9}));
			change_mode(code);
		end

		// Test 3, glitch shorter than debounce
		other = code ^ 4'b0001;
		wait_hsync_start();
		t0 = $time;
		wait_cycles(3);
		sw = other;
		wait_cycles(DEB / 2);
		sw = code;
		wait_cycles(DEB + 8);
		wait_hsync_start();
		t1 = $time;
		assert (((t1 - t0) / 20) % m_total == 0) else begin
			$display("[ERROR] %0t line phase moved after short glitch", $time);
			errors++;
		end

		// Test 4, bursts at legal columns
		for (int i = 0; i < N_AUX; i++) begin
			nb  = bursts;
			col = m_active + $urandom % (m_total - BURST - m_active + 1);
			send_word(col, $urandom);
			@(negedge clk50m_bufg);
			while (bursts == nb) @(negedge clk50m_bufg);
		end

		// Test 5, illegal columns are dropped
		for (int i = 0; i < N_BAD; i++) begin
			nb = bursts;
			if ($urandom % 2)
				col = $urandom % m_active;
			else
				col = m_total - BURST + 1 + $urandom % (4096 - (m_total - BURST + 1));
			send_word(col, $urandom);
			wait_cycles(2 * m_total);
			assert (bursts == nb) else begin
				$display("[ERROR] %0t burst for column %0d", $time, col);
				errors++;
			end
		end
		wait_cycles(2 * m_total);                    // Idle queue, no pops

		$display("Errors: top %0d, checker %0d", errors, chk_errors);
		if (errors == 0 && chk_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- flist.f
vid_pkg.sv
mode_select.sv
raster_timing.sv
aux_scheduler.sv
video_out_stage.sv
dvi_timing_top.sv
tb_dvi_checks.sv
tb_dvi_timing.sv

//--- Bender.yml
package:
  name: dvi_timing

sources:
  - vid_pkg.sv
  - mode_select.sv
  - raster_timing.sv
  - aux_scheduler.sv
  - video_out_stage.sv
  - dvi_timing_top.sv
  - target: test
    files:
      - tb_dvi_checks.sv
      - tb_dvi_timing.sv
